/* filelist.f */
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/exec_alu.sv
verilog/ex_mem_reg.sv
verilog/mem_access.sv
verilog/ex_mem_top.sv
verif/ex_mem_clkgen.sv
verif/ex_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing -f filelist.f --top-module ex_mem_tb -o ex_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ex_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0

/* verif/ex_mem_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 16;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Release on a falling edge, away from the capture edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/ex_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_tb;

    localparam int          W              = rv_isa_pkg::CPU_WIDTH;
    localparam int          NUM_ITEMS      = 600;
    localparam int          TIMEOUT_CYCLES = 16 + NUM_ITEMS * 4 + 100;
    localparam logic [31:0] SEED           = 32'h6cea;

    logic                 clk;
    logic                 rst_n;
    rv_pipe_pkg::flow_e   flow;
    rv_pipe_pkg::ex_req_t ex_req;
    logic                 acc_mem_pre;
    rv_pipe_pkg::wb_t     wb;

    // Reference model state and its own data memory
    rv_pipe_pkg::ex_res_t m_slot;
    logic                 m_acc;
    logic                 m_fire;
    logic [W-1:0]         m_mem [rv_isa_pkg::DMEM_DEPTH];
    int                   cycles = 0;

    ex_mem_clkgen i_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ex_mem_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flow_i        (flow),
        .ex_req_i      (ex_req),
        .acc_mem_pre_o (acc_mem_pre),
        .wb_o          (wb)
    );

    // ------------------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------------------
    function automatic logic [W-1:0] alu_ref(rv_isa_pkg::alu_op_e op, logic [W-1:0] a,
                                             logic [W-1:0] b);
        case (op)
            rv_isa_pkg::ADD:    return a + b;
            rv_isa_pkg::SUB:    return a - b;
            rv_isa_pkg::AND:    return a & b;
            rv_isa_pkg::OR:     return a | b;
            rv_isa_pkg::XOR:    return a ^ b;
            rv_isa_pkg::SLL:    return a << b[4:0];
            rv_isa_pkg::SRL:    return a >> b[4:0];
            rv_isa_pkg::SRA:    return $signed(a) >>> b[4:0];
            rv_isa_pkg::SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::SLTU:   return (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::PASS_B: return b;
            default:            return '0;
        endcase
    endfunction

    function automatic logic acc_flag_ref(rv_pipe_pkg::ex_req_t req);
        if (req.res_op == rv_pipe_pkg::RESCTRL_MEM)
            return 1'b1;
        return (req.res_op == rv_pipe_pkg::RESCTRL_REG) && (req.inst[6:0] == rv_isa_pkg::LOAD);
    endfunction

    // Random ALU, immediate, LUI, load or store request
    function automatic rv_pipe_pkg::ex_req_t rand_req();
        rv_pipe_pkg::ex_req_t req;
        rv_isa_pkg::opcode_e  opc;
        logic [31:0]          kind;
        logic [31:0]          r;
        logic [31:0]          op;
        logic [31:0]          word;
        logic [31:0]          off;
        kind = $urandom_range(0, 9);
        r    = $urandom();
        op   = $urandom_range(0, 9);
        // Narrow address range so loads often hit earlier stores
        word = $urandom_range(0, 11);
        off  = $urandom_range(0, 3);
        req             = '0;
        req.valid       = ($urandom_range(0, 9) != 0);
        req.pc          = {r[31:2], 2'b00};
        req.rs1_data    = $urandom();
        req.rs2_data    = $urandom();
        req.reg_wr_addr = r[4:0];
        req.alu_op      = rv_isa_pkg::alu_op_e'(op[3:0]);
        req.res_op      = rv_pipe_pkg::RESCTRL_REG;
        req.reg_wr_en   = 1'b1;
        if (kind < 3) begin
            opc = rv_isa_pkg::OP;
        end else if (kind < 5) begin
            opc         = rv_isa_pkg::OP_IMM;
            req.use_imm = 1'b1;
            req.imm     = {{20{r[11]}}, r[11:0]};
        end else if (kind < 6) begin
            opc         = rv_isa_pkg::LUI;
            req.use_imm = 1'b1;
            req.alu_op  = rv_isa_pkg::PASS_B;
            req.imm     = {r[31:12], 12'b0};
        end else begin
            opc          = (kind < 8) ? rv_isa_pkg::LOAD : rv_isa_pkg::STORE;
            req.use_imm  = 1'b1;
            req.alu_op   = rv_isa_pkg::ADD;
            req.rs1_data = word << 2;
            req.imm      = off << 2;
            if (opc == rv_isa_pkg::STORE) begin
                req.res_op    = rv_pipe_pkg::RESCTRL_MEM;
                req.reg_wr_en = 1'b0;
            end
        end
        // Some empty slots come as decode bubbles
        if (!req.valid && r[5]) begin
            req.res_op    = rv_pipe_pkg::RESCTRL_NONE;
            req.reg_wr_en = 1'b0;
        end
        req.inst = {r[31:7], opc};
        return req;
    endfunction

    // Advance the model by one rising edge and return the expected writeback
    task automatic model_edge(input rv_pipe_pkg::flow_e f, input rv_pipe_pkg::ex_req_t req,
                              output rv_pipe_pkg::wb_t exp);
        logic [rv_isa_pkg::DMEM_AW-1:0] idx;
        logic [W-1:0]                   b;
        idx             = m_slot.alu_res[rv_isa_pkg::DMEM_AW+1:2];
        exp             = '0;
        exp.valid       = m_fire;
        exp.reg_wr_en   = m_fire && m_slot.reg_wr_en;
        exp.reg_wr_addr = m_slot.reg_wr_addr;
        exp.pc          = m_slot.pc;
        exp.wr_data     = m_slot.is_load ? m_mem[idx] : m_slot.alu_res;
        if (m_fire && m_acc && (m_slot.res_op == rv_pipe_pkg::RESCTRL_MEM)) begin
            m_mem[idx] = m_slot.rs2_data;
        end
        case (f)
            rv_pipe_pkg::FLOW_WORK: begin
                b                  = req.use_imm ? req.imm : req.rs2_data;
                m_slot.valid       = req.valid;
                m_slot.inst        = req.inst;
                m_slot.pc          = req.pc;
                m_slot.alu_res     = alu_ref(req.alu_op, req.rs1_data, b);
                m_slot.rs2_data    = req.rs2_data;
                m_slot.res_op      = req.res_op;
                m_slot.is_load     = (req.inst[6:0] == rv_isa_pkg::LOAD);
                m_slot.reg_wr_en   = req.reg_wr_en;
                m_slot.reg_wr_addr = req.reg_wr_addr;
                m_acc              = acc_flag_ref(req);
                m_fire             = req.valid;
            end
            rv_pipe_pkg::FLOW_STOP: m_fire = 1'b0;
            default: begin
                m_slot        = '0;
                m_slot.res_op = rv_pipe_pkg::RESCTRL_NONE;
                m_acc         = 1'b0;
                m_fire        = 1'b0;
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic compare_wb(input rv_pipe_pkg::wb_t act, input rv_pipe_pkg::wb_t exp);
        logic bad;
        bad = (act.valid !== exp.valid) || (act.reg_wr_en !== exp.reg_wr_en);
        // Data fields only mean something on a valid writeback
        if (exp.valid) begin
            bad = bad || (act.reg_wr_addr !== exp.reg_wr_addr) ||
                  (act.wr_data !== exp.wr_data) || (act.pc !== exp.pc);
        end
        if (bad) begin
            $display("** Error at %0d ns: wb_o valid=%0b we=%0b rd=%0d data=%h pc=%h",
                     $time, act.valid, act.reg_wr_en, act.reg_wr_addr, act.wr_data, act.pc);
            $display("    expected valid=%0b we=%0b rd=%0d data=%h pc=%h",
                     exp.valid, exp.reg_wr_en, exp.reg_wr_addr, exp.wr_data, exp.pc);
            $display("ERRORS FOUND");
            $fatal(1, "writeback mismatch");
        end
    endtask

    task automatic compare_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s is %0b, expected %0b", $time, what, act, exp);
            $display("ERRORS FOUND");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Drive on the falling edge and check the result one edge later
    task automatic step(input rv_pipe_pkg::flow_e f, input rv_pipe_pkg::ex_req_t req);
        rv_pipe_pkg::wb_t exp;
        flow   = f;
        ex_req = req;
        #1;
        compare_flag(acc_mem_pre, acc_flag_ref(req), "acc_mem_pre_o");
        @(negedge clk);
        model_edge(f, req, exp);
        compare_wb(wb, exp);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        rv_pipe_pkg::ex_req_t next_req;
        rv_pipe_pkg::flow_e   next_flow;
        logic [31:0]          pick;
        int                   sent;
        void'($urandom(SEED));
        sent          = 0;
        flow          = rv_pipe_pkg::FLOW_WORK;
        ex_req        = '0;
        m_slot        = '0;
        m_slot.res_op = rv_pipe_pkg::RESCTRL_NONE;
        m_acc         = 1'b0;
        m_fire        = 1'b0;
        for (int i = 0; i < rv_isa_pkg::DMEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        next_req = rand_req();
        @(posedge rst_n);
        compare_flag(wb.valid, 1'b0, "wb_o.valid after reset");
        // An item waits at the input until a work cycle takes it
        while (sent < NUM_ITEMS) begin
            pick = $urandom_range(0, 9);
            if (pick < 7)
                next_flow = rv_pipe_pkg::FLOW_WORK;
            else if (pick < 9)
                next_flow = rv_pipe_pkg::FLOW_STOP;
            else
                next_flow = rv_pipe_pkg::FLOW_REFRESH;
            step(next_flow, next_req);
            if (next_flow == rv_pipe_pkg::FLOW_WORK) begin
                sent++;
                next_req = rand_req();
            end
        end
        // Drain
        next_req        = '0;
        next_req.res_op = rv_pipe_pkg::RESCTRL_NONE;
        repeat (3) step(rv_pipe_pkg::FLOW_WORK, next_req);
        $display("NO ERRORS");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation hung, no end after %0d clock cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_mem_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::flow_e   flow_i,
    input  rv_pipe_pkg::ex_res_t ex_res_i,
    input  logic                 acc_mem_pre_i,
    output rv_pipe_pkg::ex_res_t mem_req_o,
    output logic                 acc_mem_o,
    output logic                 mem_fire_o
);

    rv_pipe_pkg::ex_res_t mem_req_q;
    logic                 acc_mem_q;
    logic                 mem_fire_q;

    // ------------------------------------------------------------------------
    // EX/MEM register under the flow command
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req_q  <= rv_pipe_pkg::EX_RES_BUBBLE;
            acc_mem_q  <= 1'b0;
            mem_fire_q <= 1'b0;
        end else begin
            case (flow_i)
                rv_pipe_pkg::FLOW_WORK: begin
                    mem_req_q  <= ex_res_i;
                    acc_mem_q  <= acc_mem_pre_i;
                    mem_fire_q <= ex_res_i.valid;
                end
                rv_pipe_pkg::FLOW_STOP: begin
                    // Contents hold, fire drops so the
                    // held item is not performed again
                    mem_req_q  <= mem_req_q;
                    acc_mem_q  <= acc_mem_q;
                    mem_fire_q <= 1'b0;
                end
                default: begin
                    // Refresh, and any unknown command, flushes the slot
                    mem_req_q  <= rv_pipe_pkg::EX_RES_BUBBLE;
                    acc_mem_q  <= 1'b0;
                    mem_fire_q <= 1'b0;
                end
            endcase
        end
    end

    assign mem_req_o  = mem_req_q;
    assign acc_mem_o  = acc_mem_q;
    assign mem_fire_o = mem_fire_q;

endmodule

`default_nettype wire

/* verilog/ex_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::flow_e   flow_i,
    input  rv_pipe_pkg::ex_req_t ex_req_i,
    output logic                 acc_mem_pre_o,
    output rv_pipe_pkg::wb_t     wb_o
);

    rv_pipe_pkg::ex_res_t ex_res;
    rv_pipe_pkg::ex_res_t mem_req;
    logic                 acc_mem;
    logic                 mem_fire;

    // Execute
    exec_alu i_exec_alu (
        .ex_req_i      (ex_req_i),
        .ex_res_o      (ex_res),
        .acc_mem_pre_o (acc_mem_pre_o)
    );

    // EX/MEM boundary
    ex_mem_reg i_ex_mem_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .flow_i        (flow_i),
        .ex_res_i      (ex_res),
        .acc_mem_pre_i (acc_mem_pre_o),
        .mem_req_o     (mem_req),
        .acc_mem_o     (acc_mem),
        .mem_fire_o    (mem_fire)
    );

    // Memory access and writeback
    mem_access i_mem_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req_i  (mem_req),
        .acc_mem_i  (acc_mem),
        .mem_fire_i (mem_fire),
        .wb_o       (wb_o)
    );

endmodule

`default_nettype wire

/* verilog/exec_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
    input  rv_pipe_pkg::ex_req_t ex_req_i,
    output rv_pipe_pkg::ex_res_t ex_res_o,
    output logic                 acc_mem_pre_o
);

    rv_isa_pkg::opcode_e                  opcode;
    logic [rv_isa_pkg::CPU_WIDTH-1:0]     op_a;
    logic [rv_isa_pkg::CPU_WIDTH-1:0]     op_b;
    logic [rv_isa_pkg::SHAMT_WIDTH-1:0]   shamt;
    logic [rv_isa_pkg::CPU_WIDTH-1:0]     alu_res;

    assign opcode = rv_isa_pkg::opcode_e'(ex_req_i.inst[rv_isa_pkg::OPCODE_WIDTH-1:0]);

    // Operand select
    assign op_a  = ex_req_i.rs1_data;
    assign op_b  = ex_req_i.use_imm ? ex_req_i.imm : ex_req_i.rs2_data;
    assign shamt = op_b[rv_isa_pkg::SHAMT_WIDTH-1:0];

    // ------------------------------------------------------------------------
    // ALU, also forms the load/store address
    // ------------------------------------------------------------------------
    always_comb begin
        case (ex_req_i.alu_op)
            rv_isa_pkg::ADD:    alu_res = op_a + op_b;
            rv_isa_pkg::SUB:    alu_res = op_a - op_b;
            rv_isa_pkg::AND:    alu_res = op_a & op_b;
            rv_isa_pkg::OR:     alu_res = op_a | op_b;
            rv_isa_pkg::XOR:    alu_res = op_a ^ op_b;
            rv_isa_pkg::SLL:    alu_res = op_a << shamt;
            rv_isa_pkg::SRL:    alu_res = op_a >> shamt;
            rv_isa_pkg::SRA:    alu_res = $signed(op_a) >>> shamt;
            rv_isa_pkg::SLT: begin
                alu_res = {{(rv_isa_pkg::CPU_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            rv_isa_pkg::SLTU: begin
                alu_res = {{(rv_isa_pkg::CPU_WIDTH-1){1'b0}}, op_a < op_b};
            end
            // LUI, immediate already shifted by decode
            rv_isa_pkg::PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // Early memory-access flag, a load still targets the register file
    assign acc_mem_pre_o = (ex_req_i.res_op == rv_pipe_pkg::RESCTRL_MEM) ||
                           ((ex_req_i.res_op == rv_pipe_pkg::RESCTRL_REG) &&
                            (opcode == rv_isa_pkg::LOAD));

    // ------------------------------------------------------------------------
    // Result payload
    // ------------------------------------------------------------------------
    always_comb begin
        ex_res_o.valid       = ex_req_i.valid;
        ex_res_o.inst        = ex_req_i.inst;
        ex_res_o.pc          = ex_req_i.pc;
        ex_res_o.alu_res     = alu_res;
        ex_res_o.rs2_data    = ex_req_i.rs2_data;
        ex_res_o.res_op      = ex_req_i.res_op;
        ex_res_o.is_load     = (opcode == rv_isa_pkg::LOAD);
        ex_res_o.reg_wr_en   = ex_req_i.reg_wr_en;
        ex_res_o.reg_wr_addr = ex_req_i.reg_wr_addr;
    end

endmodule

`default_nettype wire

/* verilog/mem_access.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_access (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::ex_res_t mem_req_i,
    input  logic                 acc_mem_i,
    input  logic                 mem_fire_i,
    output rv_pipe_pkg::wb_t     wb_o
);

    logic [rv_isa_pkg::CPU_WIDTH-1:0] dmem [rv_isa_pkg::DMEM_DEPTH];

    logic [rv_isa_pkg::DMEM_AW-1:0]   word_addr;
    logic [rv_isa_pkg::CPU_WIDTH-1:0] rd_data;
    logic [rv_isa_pkg::CPU_WIDTH-1:0] wb_data;
    logic                             store_en;
    rv_pipe_pkg::wb_t                 wb_q;

    // Word index, byte offset dropped
    assign word_addr = mem_req_i.alu_res[rv_isa_pkg::DMEM_AW+1:2];

    assign store_en = mem_fire_i && acc_mem_i &&
                      (mem_req_i.res_op == rv_pipe_pkg::RESCTRL_MEM);

    // ------------------------------------------------------------------------
    // Data memory
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_en) begin
            dmem[word_addr] <= mem_req_i.rs2_data;
        end
    end

    // Load data seen before the store edge
    assign rd_data = dmem[word_addr];
    assign wb_data = mem_req_i.is_load ? rd_data : mem_req_i.alu_res;

    // ------------------------------------------------------------------------
    // Writeback register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q.valid     <= 1'b0;
            wb_q.reg_wr_en <= 1'b0;
        end else begin
            wb_q.valid     <= mem_fire_i;
            wb_q.reg_wr_en <= mem_fire_i & mem_req_i.reg_wr_en;
        end
        wb_q.reg_wr_addr <= mem_req_i.reg_wr_addr;
        wb_q.wr_data     <= wb_data;
        wb_q.pc          <= mem_req_i.pc;
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------
    localparam int CPU_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPCODE_WIDTH   = 7;
    localparam int SHAMT_WIDTH    = 5;

    // Word-addressed data memory
    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_AW    = 6;

    // ------------------------------------------------------------------------
    // Major opcodes, inst[6:0]
    // ------------------------------------------------------------------------
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111
    } opcode_e;

    // ALU operations as chosen by decode
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

/* verilog/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    // ------------------------------------------------------------------------
    // Pipeline control
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'b00,
        FLOW_STOP    = 2'b01,
        FLOW_REFRESH = 2'b10
    } flow_e;

    // Destination of a result, NONE marks a bubble
    typedef enum logic [1:0] {
        RESCTRL_REG  = 2'b00,
        RESCTRL_MEM  = 2'b01,
        RESCTRL_NONE = 2'b11
    } resctrl_e;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                                  valid;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      inst;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      pc;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      rs1_data;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      rs2_data;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      imm;
        rv_isa_pkg::alu_op_e                   alu_op;
        logic                                  use_imm;
        resctrl_e                              res_op;
        logic                                  reg_wr_en;
        logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] reg_wr_addr;
    } ex_req_t;

    // Held in the EX/MEM register
    typedef struct packed {
        logic                                  valid;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      inst;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      pc;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      alu_res;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      rs2_data;
        resctrl_e                              res_op;
        logic                                  is_load;
        logic                                  reg_wr_en;
        logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] reg_wr_addr;
    } ex_res_t;

    typedef struct packed {
        logic                                  valid;
        logic                                  reg_wr_en;
        logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] reg_wr_addr;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      wr_data;
        logic [rv_isa_pkg::CPU_WIDTH-1:0]      pc;
    } wb_t;

    // Empty slot loaded on reset and refresh
    localparam ex_res_t EX_RES_BUBBLE = '{
        valid:       1'b0,
        inst:        '0,
        pc:          '0,
        alu_res:     '0,
        rs2_data:    '0,
        res_op:      RESCTRL_NONE,
        is_load:     1'b0,
        reg_wr_en:   1'b0,
        reg_wr_addr: '0
    };

endpackage

`default_nettype wire
